/* blur/blur_kernel.sv */
`timescale 1ns/100ps

module blur_kernel
    import blur_pkg::*;
(
    input  window_t window,
    output pixel_t  blurred
);

    localparam int CHANNELS = $bits(pixel_t) / CHANNEL_BITS;

    // Channel planes of the window, channel 0 is blue and 2 is red
    channel_t  planes [CHANNELS][WINDOW_SIZE];
    blur_sum_t sums [CHANNELS];

    // Weights are powers of two, so each term is a shift
    function automatic blur_sum_t weighted(input channel_t value, input weight_t weight);
        blur_sum_t term;
        term = blur_sum_t'(value);
        case (weight)
            3'd1:    return term;
            3'd2:    return term << 1;
            3'd4:    return term << 2;
            default: return '0;
        endcase
    endfunction

    always_comb begin
        for (int ch = 0; ch < CHANNELS; ch++) begin
            for (int k = 0; k < WINDOW_SIZE; k++) begin
                planes[ch][k] = window[k][ch*CHANNEL_BITS +: CHANNEL_BITS];
            end
        end
    end

    // Weights total 64, so a sum never exceeds 960 and fits blur_sum_t
    always_comb begin
        for (int ch = 0; ch < CHANNELS; ch++) begin
            sums[ch] = '0;
            for (int k = 0; k < WINDOW_SIZE; k++) begin
                sums[ch] = sums[ch] + weighted(planes[ch][k], BLUR_WEIGHTS[k]);
            end
        end
    end

    // Normalize by keeping the top channel bits of each sum
    always_comb begin
        for (int ch = 0; ch < CHANNELS; ch++) begin
            blurred[ch*CHANNEL_BITS +: CHANNEL_BITS] = sums[ch][NORM_SHIFT +: CHANNEL_BITS];
        end
    end

endmodule

/* blur/window_buffer.sv */
`timescale 1ns/100ps

module window_buffer
    import blur_pkg::*;
#(
    parameter int IMAGE_WIDTH = 320
) (
    input  logic    clk,
    input  logic    advance,
    input  pixel_t  pixel_in,
    output window_t window
);

    // Four full lines plus the six pixels left of the current one
    localparam int DEPTH = (WINDOW_ROWS - 1) * IMAGE_WIDTH + (WINDOW_COLS - 1);

    // Index 0 is the oldest stored pixel, DEPTH-1 the most recent one
    pixel_t taps [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                taps[i] <= taps[i + 1];
            end
            taps[DEPTH-1] <= pixel_in;
        end
    end

    // Row r, column c of the window sits r lines and c pixels past the
    // oldest tap; the bottom-right corner is the pixel on the input now
    always_comb begin
        for (int r = 0; r < WINDOW_ROWS; r++) begin
            for (int c = 0; c < WINDOW_COLS; c++) begin
                if (r == WINDOW_ROWS - 1 && c == WINDOW_COLS - 1) begin
                    window[r*WINDOW_COLS + c] = pixel_in;
                end else begin
                    window[r*WINDOW_COLS + c] = taps[r*IMAGE_WIDTH + c];
                end
            end
        end
    end

endmodule

/* common/blur_pkg.sv */
package blur_pkg;

    // Colour format, three 4-bit channels per pixel
    localparam int CHANNEL_BITS = 4;

    // Red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [3*CHANNEL_BITS-1:0] pixel_t;

    typedef logic [CHANNEL_BITS-1:0] channel_t;

    // Weighted channel sum, at most 15 * 64 = 960
    typedef logic [9:0] blur_sum_t;

    // Column index, enough for lines of up to 1024 pixels
    typedef logic [9:0] col_t;

    // Blur window geometry
    localparam int WINDOW_ROWS = 5;
    localparam int WINDOW_COLS = 7;
    localparam int WINDOW_SIZE = WINDOW_ROWS * WINDOW_COLS;

    // Entry 0 is the oldest pixel (top-left), the last entry is the
    // current pixel (bottom-right); entries run row by row
    typedef pixel_t [WINDOW_SIZE-1:0] window_t;

    // A kernel weight is 0, 1, 2 or 4
    typedef logic [2:0] weight_t;

    // Kernel weights in window order
    // Heavier toward the current pixel, total of 64
    localparam weight_t BLUR_WEIGHTS [0:WINDOW_SIZE-1] = '{
        3'd0, 3'd1, 3'd1, 3'd1, 3'd2, 3'd2, 3'd2,
        3'd0, 3'd1, 3'd1, 3'd2, 3'd2, 3'd2, 3'd2,
        3'd1, 3'd1, 3'd2, 3'd2, 3'd2, 3'd2, 3'd2,
        3'd1, 3'd2, 3'd2, 3'd2, 3'd2, 3'd2, 3'd4,
        3'd2, 3'd2, 3'd2, 3'd2, 3'd2, 3'd4, 3'd4
    };

    // Divide by the weight total
    localparam int NORM_SHIFT = 6;

endpackage

/* src/blur_filter.sv */
`timescale 1ns/100ps

module blur_filter
    import blur_pkg::*;
#(
    parameter int IMAGE_WIDTH = 320
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   valid_in,
    input  logic   ready_in,
    input  logic   startofpacket_in,
    input  logic   endofpacket_in,
    input  logic   blur_enable,
    input  pixel_t data_in,
    output logic   ready_out,
    output logic   valid_out,
    output logic   startofpacket_out,
    output logic   endofpacket_out,
    output pixel_t data_out
);

    logic    advance;
    logic    window_full;
    window_t window;
    pixel_t  blurred;
    pixel_t  pixel_next;

    // No buffering here, so upstream sees downstream ready directly
    assign ready_out = ready_in;
    assign advance   = valid_in & ready_out;

    frame_position #(
        .IMAGE_WIDTH (IMAGE_WIDTH)
    ) i_frame_position (
        .clk           (clk),
        .rst           (rst),
        .advance       (advance),
        .startofpacket (startofpacket_in),
        .window_full   (window_full)
    );

    window_buffer #(
        .IMAGE_WIDTH (IMAGE_WIDTH)
    ) i_window_buffer (
        .clk      (clk),
        .advance  (advance),
        .pixel_in (data_in),
        .window   (window)
    );

    blur_kernel i_blur_kernel (
        .window  (window),
        .blurred (blurred)
    );

    // Border pixels pass through, their window reaches outside the frame
    assign pixel_next = (blur_enable && window_full) ? blurred : data_in;

    // Control half of the output register
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out         <= 1'b0;
            startofpacket_out <= 1'b0;
            endofpacket_out   <= 1'b0;
        end else if (ready_in) begin
            valid_out         <= valid_in;
            startofpacket_out <= startofpacket_in;
            endofpacket_out   <= endofpacket_in;
        end
    end

    // Pixel half, held with the flags under back-pressure
    always_ff @(posedge clk) begin
        if (ready_in) begin
            data_out <= pixel_next;
        end
    end

endmodule

/* src/frame_position.sv */
`timescale 1ns/100ps

module frame_position
    import blur_pkg::*;
#(
    parameter int IMAGE_WIDTH = 320
) (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  logic startofpacket,
    output logic window_full
);

    localparam int ROW_BITS = $clog2(WINDOW_ROWS);

    localparam col_t                LAST_COL = col_t'(IMAGE_WIDTH - 1);
    localparam col_t                FULL_COL = col_t'(WINDOW_COLS - 1);
    localparam logic [ROW_BITS-1:0] FULL_ROW = ROW_BITS'(WINDOW_ROWS - 1);

    // Position of the next pixel to arrive
    col_t                col_count;
    logic [ROW_BITS-1:0] row_count;

    // Position of the pixel on the input this cycle
    col_t                cur_col;
    logic [ROW_BITS-1:0] cur_row;

    // A start beat is pixel (0, 0) whatever the counters hold
    assign cur_col = startofpacket ? '0 : col_count;
    assign cur_row = startofpacket ? '0 : row_count;

    // Window lies inside this frame once four full rows and six
    // pixels of the current row are behind us
    assign window_full = (cur_row >= FULL_ROW) && (cur_col >= FULL_COL);

    always_ff @(posedge clk) begin
        if (rst) begin
            col_count <= '0;
            row_count <= '0;
        end else if (advance) begin
            if (cur_col == LAST_COL) begin
                col_count <= '0;
                // Row saturates, deeper rows look the same
                if (cur_row != FULL_ROW) begin
                    row_count <= cur_row + 1'b1;
                end else begin
                    row_count <= cur_row;
                end
            end else begin
                col_count <= cur_col + 1'b1;
                row_count <= cur_row;
            end
        end
    end

endmodule

/* testbench/blur_filter_sva.sv */
`timescale 1ns/100ps

module blur_filter_sva
    import blur_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   valid_in,
    input logic   ready_in,
    input logic   ready_out,
    input logic   valid_out,
    input logic   startofpacket_out,
    input logic   endofpacket_out,
    input pixel_t data_out
);

    // Output stays idle from reset until a beat is accepted
    property idle_until_accept;
        @(posedge clk) (rst || (!valid_out && !(valid_in && ready_in))) |=> !valid_out;
    endproperty

    a_idle_until_accept: assert property (idle_until_accept)
        else $error("valid_out went high without an accepted input beat");

    a_ready_through: assert property (@(posedge clk) ready_out == ready_in)
        else $error("ready_out differs from ready_in");

    // Back-pressure freezes the whole output register
    property hold_on_stall;
        @(posedge clk) disable iff (rst)
        !ready_in |=> $stable(valid_out) && $stable(startofpacket_out)
                      && $stable(endofpacket_out) && $stable(data_out);
    endproperty

    a_hold_on_stall: assert property (hold_on_stall)
        else $error("outputs changed while ready_in was low");

    property valid_follows;
        @(posedge clk) disable iff (rst)
        ready_in |=> valid_out == $past(valid_in);
    endproperty

    a_valid_follows: assert property (valid_follows)
        else $error("valid_out does not follow valid_in of the previous cycle");

endmodule

bind blur_filter blur_filter_sva i_blur_filter_sva (.*);

/* testbench/blur_filter_tb.sv */
`timescale 1ns/100ps

module blur_filter_tb
    import blur_pkg::*;
;

    localparam int IMAGE_WIDTH = 16;
    localparam int NUM_TESTS   = 6;
    localparam int MAX_PIXELS  = 8 * IMAGE_WIDTH;

    // Kernel weights row by row with the oldest pixel first
    localparam int KERNEL [0:34] = '{
        0, 1, 1, 1, 2, 2, 2,
        0, 1, 1, 2, 2, 2, 2,
        1, 1, 2, 2, 2, 2, 2,
        1, 2, 2, 2, 2, 2, 4,
        2, 2, 2, 2, 2, 4, 4
    };

    logic   clk;
    logic   rst;
    logic   valid_in;
    logic   ready_in;
    logic   startofpacket_in;
    logic   endofpacket_in;
    logic   blur_enable;
    pixel_t data_in;
    logic   ready_out;
    logic   valid_out;
    logic   startofpacket_out;
    logic   endofpacket_out;
    pixel_t data_out;

    // Stimulus table with one frame per row
    string  test_name [NUM_TESTS];
    int     test_rows [NUM_TESTS];
    bit     test_random [NUM_TESTS];
    pixel_t test_value [NUM_TESTS];
    bit     test_blur [NUM_TESTS];
    bit     test_stall [NUM_TESTS];
    bit     table_loaded = 1'b0;

    integer seed = 80510;
    int     errors = 0;
    int     checks = 0;
    int     active_test = 0;

    // Pixels of the frame being sent
    pixel_t frame_pix [0:MAX_PIXELS-1];

    // Expected output beats in order of acceptance
    pixel_t exp_data [$];
    bit     exp_sop [$];
    bit     exp_eop [$];
    int     exp_test [$];

    blur_filter #(
        .IMAGE_WIDTH (IMAGE_WIDTH)
    ) i_blur_filter (
        .clk               (clk),
        .rst               (rst),
        .valid_in          (valid_in),
        .ready_in          (ready_in),
        .startofpacket_in  (startofpacket_in),
        .endofpacket_in    (endofpacket_in),
        .blur_enable       (blur_enable),
        .data_in           (data_in),
        .ready_out         (ready_out),
        .valid_out         (valid_out),
        .startofpacket_out (startofpacket_out),
        .endofpacket_out   (endofpacket_out),
        .data_out          (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic set_test(input int idx, input string name, input int rows,
                            input bit rnd, input pixel_t value, input bit blur,
                            input bit stall);
        test_name[idx]   = name;
        test_rows[idx]   = rows;
        test_random[idx] = rnd;
        test_value[idx]  = value;
        test_blur[idx]   = blur;
        test_stall[idx]  = stall;
    endtask

    task automatic load_table();
        set_test(0, "pass_through",  6, 1'b1, 12'h000, 1'b0, 1'b0);
        set_test(1, "constant_blur", 6, 1'b0, 12'h7C3, 1'b1, 1'b0);
        set_test(2, "random_blur",   7, 1'b1, 12'h000, 1'b1, 1'b0);
        set_test(3, "back_pressure", 7, 1'b1, 12'h000, 1'b1, 1'b1);
        // Too short for any blurred pixel before a fresh frame
        set_test(4, "short_frame",   3, 1'b1, 12'h000, 1'b1, 1'b0);
        set_test(5, "frame_restart", 6, 1'b1, 12'h000, 1'b1, 1'b0);
    endtask

    function automatic int total_pixels();
        int sum;
        sum = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            sum += test_rows[t] * IMAGE_WIDTH;
        end
        return sum;
    endfunction

    // About one stalled cycle in four when back-pressure is on
    function automatic logic pick_ready(input bit stall);
        if (!stall) begin
            return 1'b1;
        end
        return (($random(seed) & 3) != 0);
    endfunction

    // Output pixel for frame index n from the blur rule
    function automatic pixel_t expected_pixel(input int n, input bit enable);
        int     row;
        int     col;
        int     sum;
        pixel_t p;
        pixel_t result;
        row = n / IMAGE_WIDTH;
        col = n % IMAGE_WIDTH;
        if (!enable || row < 4 || col < 6) begin
            return frame_pix[n];
        end
        for (int ch = 0; ch < 3; ch++) begin
            sum = 0;
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 7; j++) begin
                    p = frame_pix[(row - 4 + i) * IMAGE_WIDTH + col - 6 + j];
                    sum += KERNEL[i * 7 + j] * ((p >> (4 * ch)) & 12'hF);
                end
            end
            result[4*ch +: 4] = sum / 64;
        end
        return result;
    endfunction

    task automatic send_frame(input int t);
        int     npix;
        pixel_t pix;
        npix = test_rows[t] * IMAGE_WIDTH;
        active_test = t;
        for (int n = 0; n < npix; n++) begin
            pix = test_random[t] ? pixel_t'($random(seed)) : test_value[t];
            frame_pix[n] = pix;
            valid_in         <= 1'b1;
            data_in          <= pix;
            startofpacket_in <= (n == 0);
            endofpacket_in   <= (n == npix - 1);
            blur_enable      <= test_blur[t];
            ready_in         <= pick_ready(test_stall[t]);
            @(posedge clk);
            // Hold the beat until the DUT takes it
            while (!ready_in) begin
                ready_in <= pick_ready(test_stall[t]);
                @(posedge clk);
            end
            exp_data.push_back(expected_pixel(n, test_blur[t]));
            exp_sop.push_back(n == 0);
            exp_eop.push_back(n == npix - 1);
            exp_test.push_back(t);
        end
    endtask

    // Output beats leave when valid_out and ready_in meet at an edge
    always @(posedge clk) begin
        pixel_t e_data;
        bit     e_sop;
        bit     e_eop;
        int     t;
        // Downstream ready reaches upstream unchanged
        if (!rst) begin
            assert (ready_out == ready_in) else begin
                errors++;
                $display("Fail %s ready: expected %0b, actual %0b",
                         test_name[active_test], ready_in, ready_out);
            end
        end
        if (!rst && valid_out && ready_in) begin
            assert (exp_data.size() != 0) else begin
                errors++;
                $display("Output beat %h appeared with no matching input beat", data_out);
            end
            if (exp_data.size() != 0) begin
                e_data = exp_data.pop_front();
                e_sop  = exp_sop.pop_front();
                e_eop  = exp_eop.pop_front();
                t      = exp_test.pop_front();
                checks++;
                assert (data_out == e_data) else begin
                    errors++;
                    $display("Fail %s data: expected %h, actual %h",
                             test_name[t], e_data, data_out);
                end
                assert (startofpacket_out == e_sop) else begin
                    errors++;
                    $display("Fail %s start: expected %0b, actual %0b",
                             test_name[t], e_sop, startofpacket_out);
                end
                assert (endofpacket_out == e_eop) else begin
                    errors++;
                    $display("Fail %s end: expected %0b, actual %0b",
                             test_name[t], e_eop, endofpacket_out);
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (table_loaded);
        limit = total_pixels() * 4 + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d clock periods, the output stream did not drain", limit);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : stimulus
        int guard;
        rst              = 1'b1;
        valid_in         = 1'b0;
        ready_in         = 1'b1;
        startofpacket_in = 1'b0;
        endofpacket_in   = 1'b0;
        blur_enable      = 1'b0;
        data_in          = '0;
        load_table();
        table_loaded = 1'b1;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            send_frame(t);
        end
        valid_in         <= 1'b0;
        startofpacket_in <= 1'b0;
        endofpacket_in   <= 1'b0;
        blur_enable      <= 1'b0;
        ready_in         <= 1'b1;

        guard = 0;
        while (exp_data.size() != 0 && guard < 50) begin
            @(posedge clk);
            guard++;
        end
        // A few idle cycles to catch stray output beats
        repeat (4) @(posedge clk);
        assert (exp_data.size() == 0) else begin
            errors++;
            $display("%0d expected output beats never appeared", exp_data.size());
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/blur_pkg.sv
src/frame_position.sv
blur/window_buffer.sv
blur/blur_kernel.sv
src/blur_filter.sv
testbench/blur_filter_sva.sv
testbench/blur_filter_tb.sv
